// ==== source/isa_pkg.sv ====
package isa_pkg;

    ////////////////////////////////////////
    // Architectural sizes
    ////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM12_W    = 12;

    // First fetch address and sequential step
    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;
    localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

    // 3R format, opcode in bits 31..15
    localparam logic [16:0] OP3R_ADD_W = 17'h00020;
    localparam logic [16:0] OP3R_SUB_W = 17'h00022;
    localparam logic [16:0] OP3R_AND   = 17'h00029;
    localparam logic [16:0] OP3R_OR    = 17'h0002a;
    localparam logic [16:0] OP3R_XOR   = 17'h0002b;

    // 2RI12 format, opcode in bits 31..22
    localparam logic [9:0] OP2RI12_ADDI_W = 10'h00a;
    localparam logic [9:0] OP2RI12_ANDI   = 10'h00d;
    localparam logic [9:0] OP2RI12_ORI    = 10'h00e;

    typedef struct packed {
        logic [16:0]           opcode;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } instr_3r_t;

    typedef struct packed {
        logic [9:0]            opcode;
        logic [IMM12_W-1:0]    imm12;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } instr_2ri12_t;

    // One fetched word, seen through either format
    typedef union packed {
        instr_3r_t    r3;
        instr_2ri12_t ri12;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

endpackage

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

    // Instruction FIFO sizing
    localparam int IB_DEPTH = 4;
    localparam int IB_PTR_W = $clog2(IB_DEPTH);
    localparam int IB_CNT_W = $clog2(IB_DEPTH + 1);

    // FIFO entry, stamped with its PC on acceptance
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0] pc;
        logic [isa_pkg::XLEN-1:0] instr;
    } ib_entry_t;

    // Decoded operation held in the decode register
    typedef struct packed {
        logic                           valid;
        logic [isa_pkg::XLEN-1:0]       pc;
        isa_pkg::alu_op_e               alu_op;
        logic [isa_pkg::REG_ADDR_W-1:0] rj;
        logic [isa_pkg::REG_ADDR_W-1:0] rk;
        logic                           use_imm;
        logic [isa_pkg::XLEN-1:0]       imm;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic                           wen;
    } dec_op_t;

    // Execute result, also the shape of the commit trace
    typedef struct packed {
        logic                           valid;
        logic [isa_pkg::XLEN-1:0]       pc;
        logic                           wen;
        logic [isa_pkg::REG_ADDR_W-1:0] wnum;
        logic [isa_pkg::XLEN-1:0]       wdata;
    } commit_t;

endpackage

// ==== source/instr_buffer.sv ====
`timescale 1ns/1ps

module instr_buffer (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic [isa_pkg::XLEN-1:0] wb_dat_i,
    output logic                     wb_ack_o,
    output pipe_pkg::ib_entry_t      entry_o,
    output logic                     entry_valid_o
);

    pipe_pkg::ib_entry_t           mem_q [pipe_pkg::IB_DEPTH];
    logic [pipe_pkg::IB_PTR_W-1:0] wr_ptr_q;
    logic [pipe_pkg::IB_PTR_W-1:0] rd_ptr_q;
    logic [pipe_pkg::IB_CNT_W-1:0] count_q;
    logic [pipe_pkg::IB_CNT_W-1:0] count_d;
    logic [isa_pkg::XLEN-1:0]      pc_q;
    logic                          ack_q;
    logic                          push;
    logic                          pop;

    ////////////////////////////////////////
    // Wishbone slave side
    ////////////////////////////////////////

    // Ack only while the cycle is still open
    assign wb_ack_o = ack_q & wb_cyc_i & wb_stb_i;
    assign push     = wb_ack_o;

    // Downstream never stalls, so the head leaves every valid cycle
    assign pop = (count_q != '0);

    always_comb begin
        count_d = count_q;
        if (push && !pop) begin
            count_d = count_q + 1'b1;
        end else if (!push && pop) begin
            count_d = count_q - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q    <= 1'b0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            pc_q     <= isa_pkg::RESET_PC;
        end else begin
            // Single-cycle ack, held off while the FIFO would be full
            ack_q   <= wb_cyc_i & wb_stb_i & ~ack_q & (count_d < pipe_pkg::IB_DEPTH);
            count_q <= count_d;
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
                pc_q     <= pc_q + isa_pkg::PC_STEP;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= '{pc: pc_q, instr: wb_dat_i};
        end
    end

    assign entry_o       = mem_q[rd_ptr_q];
    assign entry_valid_o = pop;

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic [isa_pkg::REG_ADDR_W-1:0] raddr_a_i,
    input  logic [isa_pkg::REG_ADDR_W-1:0] raddr_b_i,
    output logic [isa_pkg::XLEN-1:0]       rdata_a_o,
    output logic [isa_pkg::XLEN-1:0]       rdata_b_o,
    input  logic                           wen_i,
    input  logic [isa_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [isa_pkg::XLEN-1:0]       wdata_i
);

    logic [isa_pkg::XLEN-1:0] regs_q [isa_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // r0 reads as zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                arst_n_i,
    input  pipe_pkg::ib_entry_t entry_i,
    input  logic                entry_valid_i,
    output pipe_pkg::dec_op_t   op_o
);

    isa_pkg::instr_u   instr;
    pipe_pkg::dec_op_t op_d;
    pipe_pkg::dec_op_t op_q;
    logic              known;

    assign instr = entry_i.instr;

    always_comb begin
        known        = 1'b1;
        op_d.valid   = entry_valid_i;
        op_d.pc      = entry_i.pc;
        op_d.alu_op  = isa_pkg::ALU_ADD;
        // rj and rd sit in the same bits in both formats
        op_d.rj      = instr.r3.rj;
        op_d.rk      = instr.r3.rk;
        op_d.rd      = instr.r3.rd;
        op_d.use_imm = 1'b0;
        op_d.imm     = '0;

        case (instr.r3.opcode)
            isa_pkg::OP3R_ADD_W: op_d.alu_op = isa_pkg::ALU_ADD;
            isa_pkg::OP3R_SUB_W: op_d.alu_op = isa_pkg::ALU_SUB;
            isa_pkg::OP3R_AND:   op_d.alu_op = isa_pkg::ALU_AND;
            isa_pkg::OP3R_OR:    op_d.alu_op = isa_pkg::ALU_OR;
            isa_pkg::OP3R_XOR:   op_d.alu_op = isa_pkg::ALU_XOR;
            default: begin
                // Not 3R, try the immediate format
                op_d.use_imm = 1'b1;
                case (instr.ri12.opcode)
                    isa_pkg::OP2RI12_ADDI_W: begin
                        op_d.alu_op = isa_pkg::ALU_ADD;
                        op_d.imm    = {{(isa_pkg::XLEN - isa_pkg::IMM12_W)
                                        {instr.ri12.imm12[isa_pkg::IMM12_W-1]}},
                                       instr.ri12.imm12};
                    end
                    isa_pkg::OP2RI12_ANDI: begin
                        op_d.alu_op = isa_pkg::ALU_AND;
                        op_d.imm    = {{(isa_pkg::XLEN - isa_pkg::IMM12_W){1'b0}},
                                       instr.ri12.imm12};
                    end
                    isa_pkg::OP2RI12_ORI: begin
                        op_d.alu_op = isa_pkg::ALU_OR;
                        op_d.imm    = {{(isa_pkg::XLEN - isa_pkg::IMM12_W){1'b0}},
                                       instr.ri12.imm12};
                    end
                    default: begin
                        // Unknown opcode retires without a write
                        known        = 1'b0;
                        op_d.use_imm = 1'b0;
                    end
                endcase
            end
        endcase

        // Writes to r0 are dropped here so commit needs no check
        op_d.wen = entry_valid_i & known & (op_d.rd != '0);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_q <= '0;
        end else begin
            op_q <= op_d;
        end
    end

    assign op_o = op_q;

endmodule

// ==== source/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  pipe_pkg::dec_op_t              op_i,
    output logic [isa_pkg::REG_ADDR_W-1:0] raddr_a_o,
    output logic [isa_pkg::REG_ADDR_W-1:0] raddr_b_o,
    input  logic [isa_pkg::XLEN-1:0]       rdata_a_i,
    input  logic [isa_pkg::XLEN-1:0]       rdata_b_i,
    output pipe_pkg::commit_t              ex_o
);

    pipe_pkg::commit_t        ex_q;
    logic [isa_pkg::XLEN-1:0] opnd_a;
    logic [isa_pkg::XLEN-1:0] opnd_rk;
    logic [isa_pkg::XLEN-1:0] opnd_b;
    logic [isa_pkg::XLEN-1:0] result;

    // Older instruction still in ex_q wins over the register file
    function automatic logic [isa_pkg::XLEN-1:0] fwd(
        input logic [isa_pkg::REG_ADDR_W-1:0] addr,
        input logic [isa_pkg::XLEN-1:0]       rdata,
        input pipe_pkg::commit_t              ex
    );
        logic hit;
        hit = ex.valid & ex.wen & (ex.wnum == addr);
        return hit ? ex.wdata : rdata;
    endfunction

    assign raddr_a_o = op_i.rj;
    assign raddr_b_o = op_i.rk;

    assign opnd_a  = fwd(op_i.rj, rdata_a_i, ex_q);
    assign opnd_rk = fwd(op_i.rk, rdata_b_i, ex_q);
    assign opnd_b  = op_i.use_imm ? op_i.imm : opnd_rk;

    always_comb begin
        case (op_i.alu_op)
            isa_pkg::ALU_ADD: result = opnd_a + opnd_b;
            isa_pkg::ALU_SUB: result = opnd_a - opnd_b;
            isa_pkg::ALU_AND: result = opnd_a & opnd_b;
            isa_pkg::ALU_OR:  result = opnd_a | opnd_b;
            isa_pkg::ALU_XOR: result = opnd_a ^ opnd_b;
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_q <= '0;
        end else begin
            ex_q.valid <= op_i.valid;
            ex_q.pc    <= op_i.pc;
            ex_q.wen   <= op_i.wen;
            ex_q.wnum  <= op_i.rd;
            ex_q.wdata <= result;
        end
    end

    assign ex_o = ex_q;

endmodule

// ==== source/commit_stage.sv ====
`timescale 1ns/1ps

module commit_stage (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  pipe_pkg::commit_t              ex_i,
    output logic                           rf_wen_o,
    output logic [isa_pkg::REG_ADDR_W-1:0] rf_waddr_o,
    output logic [isa_pkg::XLEN-1:0]       rf_wdata_o,
    output pipe_pkg::commit_t              commit_o
);

    pipe_pkg::commit_t commit_q;

    // Register file write happens in the same cycle as ex_q
    assign rf_wen_o   = ex_i.valid & ex_i.wen;
    assign rf_waddr_o = ex_i.wnum;
    assign rf_wdata_o = ex_i.wdata;

    // Trace lags the write by one cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_q <= '0;
        end else begin
            commit_q <= ex_i;
        end
    end

    assign commit_o = commit_q;

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic [isa_pkg::XLEN-1:0] wb_dat_i,
    output logic                     wb_ack_o,
    output pipe_pkg::commit_t        commit_o
);

    pipe_pkg::ib_entry_t            ib_entry;
    logic                           ib_valid;
    pipe_pkg::dec_op_t              dec_op;
    pipe_pkg::commit_t              ex_q;
    logic [isa_pkg::REG_ADDR_W-1:0] rf_raddr_a;
    logic [isa_pkg::REG_ADDR_W-1:0] rf_raddr_b;
    logic [isa_pkg::XLEN-1:0]       rf_rdata_a;
    logic [isa_pkg::XLEN-1:0]       rf_rdata_b;
    logic                           rf_wen;
    logic [isa_pkg::REG_ADDR_W-1:0] rf_waddr;
    logic [isa_pkg::XLEN-1:0]       rf_wdata;

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////
    instr_buffer u_instr_buffer (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_o     (wb_ack_o),
        .entry_o      (ib_entry),
        .entry_valid_o(ib_valid)
    );

    ////////////////////////////////////////
    // Decode, execute, registers
    ////////////////////////////////////////
    decode_stage u_decode_stage (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .entry_i      (ib_entry),
        .entry_valid_i(ib_valid),
        .op_o         (dec_op)
    );

    exec_stage u_exec_stage (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .op_i     (dec_op),
        .raddr_a_o(rf_raddr_a),
        .raddr_b_o(rf_raddr_b),
        .rdata_a_i(rf_rdata_a),
        .rdata_b_i(rf_rdata_b),
        .ex_o     (ex_q)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr_a_i(rf_raddr_a),
        .raddr_b_i(rf_raddr_b),
        .rdata_a_o(rf_rdata_a),
        .rdata_b_o(rf_rdata_b),
        .wen_i    (rf_wen),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

    ////////////////////////////////////////
    // Output side
    ////////////////////////////////////////
    commit_stage u_commit_stage (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .ex_i      (ex_q),
        .rf_wen_o  (rf_wen),
        .rf_waddr_o(rf_waddr),
        .rf_wdata_o(rf_wdata),
        .commit_o  (commit_o)
    );

endmodule

// ==== dv/cpu_top_assert.sv ====
`timescale 1ns/1ps

module cpu_top_assert (
    input logic              clk,
    input logic              arst_n_i,
    input logic              wb_cyc_i,
    input logic              wb_stb_i,
    input logic              wb_ack_o,
    input pipe_pkg::commit_t commit_o
);

    logic                     seen_q;
    logic [isa_pkg::XLEN-1:0] last_pc_q;

    // PC of the previous retired instruction
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            seen_q    <= 1'b0;
            last_pc_q <= '0;
        end else if (commit_o.valid) begin
            seen_q    <= 1'b1;
            last_pc_q <= commit_o.pc;
        end
    end

    ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i))
        else $error("ack without cyc and stb");

    ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("ack held longer than one cycle");

    pc_step: assert property (@(posedge clk) disable iff (!arst_n_i)
        (commit_o.valid && seen_q) |-> (commit_o.pc == last_pc_q + isa_pkg::PC_STEP))
        else $error("commit pc did not step");

    no_r0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        (commit_o.valid && commit_o.wen) |-> (commit_o.wnum != '0))
        else $error("commit writes r0");

endmodule

bind cpu_top cpu_top_assert u_cpu_top_assert (
    .clk     (clk),
    .arst_n_i(arst_n_i),
    .wb_cyc_i(wb_cyc_i),
    .wb_stb_i(wb_stb_i),
    .wb_ack_o(wb_ack_o),
    .commit_o(commit_o)
);

// ==== dv/tb_cpu_top.sv ====
`timescale 1ns/1ps

module tb_cpu_top;

    // 29 instructions across all tests
    localparam int TOTAL_INSTR = 29;
    localparam int TIMEOUT_CYC = TOTAL_INSTR * 20 + 200;

    logic              clk;
    logic              arst_n;
    logic              wb_cyc;
    logic              wb_stb;
    logic [31:0]       wb_dat;
    logic              wb_ack;
    pipe_pkg::commit_t commit;

    logic [31:0]       model_regs [32];
    logic [31:0]       exp_pc;
    logic [31:0]       rng_state;
    logic [31:0]       prog_q [$];
    pipe_pkg::commit_t exp_q [$];
    pipe_pkg::commit_t commit_q [$];
    int                checks;
    int                errors;
    int                test_errs;
    int                ack_waits;

    cpu_top dut0 (
        .clk     (clk),
        .arst_n_i(arst_n),
        .wb_cyc_i(wb_cyc),
        .wb_stb_i(wb_stb),
        .wb_dat_i(wb_dat),
        .wb_ack_o(wb_ack),
        .commit_o(commit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Trace monitor
    always @(posedge clk) begin
        if (commit.valid) begin
            commit_q.push_back(commit);
        end
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Timeout: the pipeline did not retire all instructions in time");
        $display("sim failed");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri(input logic [9:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Reference model of one instruction
    task automatic predict(input logic [31:0] w);
        logic [4:0]        rd;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       imm_s;
        logic [31:0]       imm_z;
        logic [31:0]       res;
        logic              known;
        pipe_pkg::commit_t c;
        rd    = w[4:0];
        a     = model_regs[w[9:5]];
        b     = model_regs[w[14:10]];
        imm_s = {{20{w[21]}}, w[21:10]};
        imm_z = {20'b0, w[21:10]};
        known = 1'b1;
        res   = '0;
        case (w[31:15])
            isa_pkg::OP3R_ADD_W: res = a + b;
            isa_pkg::OP3R_SUB_W: res = a - b;
            isa_pkg::OP3R_AND:   res = a & b;
            isa_pkg::OP3R_OR:    res = a | b;
            isa_pkg::OP3R_XOR:   res = a ^ b;
            default: begin
                case (w[31:22])
                    isa_pkg::OP2RI12_ADDI_W: res = a + imm_s;
                    isa_pkg::OP2RI12_ANDI:   res = a & imm_z;
                    isa_pkg::OP2RI12_ORI:    res = a | imm_z;
                    default:                 known = 1'b0;
                endcase
            end
        endcase
        c.valid = 1'b1;
        c.pc    = exp_pc;
        c.wen   = known && (rd != 5'd0);
        c.wnum  = rd;
        c.wdata = res;
        if (c.wen) begin
            model_regs[rd] = res;
        end
        exp_pc = exp_pc + 32'd4;
        exp_q.push_back(c);
    endtask

    // Called right after a rising edge; returns at the ack edge
    task automatic wb_write(input logic [31:0] data);
        logic acked;
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_dat = data;
        do begin
            @(posedge clk);
            acked = wb_ack;
            if (!acked) begin
                ack_waits++;
            end
        end while (!acked);
    endtask

    task automatic bus_idle();
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_dat = '0;
    endtask

    // Issue prog_q back to back, then compare the trace in order
    task automatic run_prog();
        pipe_pkg::commit_t got;
        pipe_pkg::commit_t exp;
        foreach (prog_q[i]) begin
            predict(prog_q[i]);
            wb_write(prog_q[i]);
        end
        bus_idle();
        while (commit_q.size() < exp_q.size()) @(posedge clk);
        repeat (3) @(posedge clk);
        check_val("commit count", commit_q.size(), exp_q.size());
        while (exp_q.size() > 0 && commit_q.size() > 0) begin
            got = commit_q.pop_front();
            exp = exp_q.pop_front();
            check_val("commit pc", got.pc, exp.pc);
            check_val("commit wen", got.wen, exp.wen);
            check_val("commit wnum", got.wnum, exp.wnum);
            if (exp.wen) begin
                check_val("commit wdata", got.wdata, exp.wdata);
            end
        end
        exp_q.delete();
        commit_q.delete();
        prog_q.delete();
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_errs);
        test_errs = errors;
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic test_reset();
        repeat (8) begin
            @(posedge clk);
            check_val("idle commit valid", commit.valid, 1'b0);
            check_val("idle ack", wb_ack, 1'b0);
        end
        // First retired PC must be the reset PC
        prog_q.push_back(enc_ri(isa_pkg::OP2RI12_ORI, 5'd1, 5'd0, 12'(xorshift())));
        run_prog();
        end_test("reset");
    endtask

    task automatic test_imm();
        prog_q.push_back(enc_ri(isa_pkg::OP2RI12_ORI, 5'd2, 5'd0, 12'(xorshift())));
        prog_q.push_back(enc_ri(isa_pkg::OP2RI12_ADDI_W, 5'd3, 5'd2,
                                12'(xorshift()) | 12'h800));
        prog_q.push_back(enc_ri(isa_pkg::OP2RI12_ANDI, 5'd4, 5'd3, 12'(xorshift())));
        prog_q.push_back(enc_ri(isa_pkg::OP2RI12_ORI, 5'd5, 5'd3, 12'(xorshift())));
        run_prog();
        end_test("imm");
    endtask

    task automatic test_3r();
        prog_q.push_back(enc_ri(isa_pkg::OP2RI12_ADDI_W, 5'd6, 5'd0, 12'(xorshift())));
        prog_q.push_back(enc_ri(isa_pkg::OP2RI12_ADDI_W, 5'd7, 5'd0,
                                12'(xorshift()) | 12'h800));
        prog_q.push_back(enc_3r(isa_pkg::OP3R_ADD_W, 5'd8, 5'd6, 5'd7));
        prog_q.push_back(enc_3r(isa_pkg::OP3R_SUB_W, 5'd9, 5'd6, 5'd7));
        prog_q.push_back(enc_3r(isa_pkg::OP3R_AND, 5'd10, 5'd6, 5'd7));
        prog_q.push_back(enc_3r(isa_pkg::OP3R_OR, 5'd11, 5'd6, 5'd7));
        prog_q.push_back(enc_3r(isa_pkg::OP3R_XOR, 5'd12, 5'd6, 5'd7));
        run_prog();
        end_test("3r");
    endtask

    task automatic test_chain();
        prog_q.push_back(enc_ri(isa_pkg::OP2RI12_ORI, 5'd20, 5'd0, 12'(xorshift())));
        prog_q.push_back(enc_3r(isa_pkg::OP3R_ADD_W, 5'd20, 5'd20, 5'd20));
        prog_q.push_back(enc_3r(isa_pkg::OP3R_SUB_W, 5'd20, 5'd20, 5'd7));
        prog_q.push_back(enc_3r(isa_pkg::OP3R_XOR, 5'd20, 5'd20, 5'd6));
        prog_q.push_back(enc_ri(isa_pkg::OP2RI12_ADDI_W, 5'd20, 5'd20,
                                12'(xorshift()) | 12'h800));
        prog_q.push_back(enc_3r(isa_pkg::OP3R_OR, 5'd21, 5'd20, 5'd20));
        run_prog();
        end_test("chain");
    endtask

    task automatic test_burst();
        for (int i = 0; i < 2 * pipe_pkg::IB_DEPTH; i++) begin
            prog_q.push_back(enc_ri(isa_pkg::OP2RI12_ADDI_W, 5'(16 + i), 5'(15 + i),
                                    12'(xorshift())));
        end
        ack_waits = 0;
        run_prog();
        // Each write waits one cycle for its registered ack
        check_val("burst ack waits", ack_waits, 2 * pipe_pkg::IB_DEPTH);
        end_test("burst");
    endtask

    task automatic test_r0();
        prog_q.push_back(enc_ri(isa_pkg::OP2RI12_ADDI_W, 5'd0, 5'd6, 12'd5));
        // Matches neither opcode field
        prog_q.push_back(32'hffff_ffff);
        prog_q.push_back(enc_3r(isa_pkg::OP3R_ADD_W, 5'd13, 5'd0, 5'd0));
        run_prog();
        end_test("r0");
    endtask

    initial begin
        arst_n    = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_dat    = '0;
        rng_state = 32'haf88_5baa;
        exp_pc    = isa_pkg::RESET_PC;
        checks    = 0;
        errors    = 0;
        test_errs = 0;
        ack_waits = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        @(posedge clk);

        test_reset();
        test_imm();
        test_3r();
        test_chain();
        test_burst();
        test_r0();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/instr_buffer.sv
source/reg_file.sv
source/decode_stage.sv
source/exec_stage.sv
source/commit_stage.sv
source/cpu_top.sv
dv/cpu_top_assert.sv
dv/tb_cpu_top.sv

// ==== Bender.yml ====
package:
  name: cpu_top

sources:
  - source/isa_pkg.sv
  - source/pipe_pkg.sv
  - source/instr_buffer.sv
  - source/reg_file.sv
  - source/decode_stage.sv
  - source/exec_stage.sv
  - source/commit_stage.sv
  - source/cpu_top.sv
  - target: test
    files:
      - dv/cpu_top_assert.sv
      - dv/tb_cpu_top.sv
